//--- Makefile
SIM  := obj_dir/Vdata_mem_tb
SRCS := $(shell cat flist.f)

.PHONY: all run clean

all: run

$(SIM): flist.f $(SRCS)
	verilator --binary --timing --assert -f flist.f --top-module data_mem_tb -o Vdata_mem_tb

run: $(SIM)
	./$(SIM) +verilator+error+limit+100 > sim.log 2>&1 || true
	cat sim.log
	grep -q "^STATUS: PASS$$" sim.log

clean:
	rm -rf obj_dir sim.log

//--- bench/data_mem_checker.sv
// Bound checks for the data memory
// Lane write mask against size and offset, read-valid latency
`timescale 1ns/1ps
`default_nettype none

module data_mem_checker (
    input logic                    clk,
    input logic                    i_rst,
    input logic                    i_wen,
    input logic [1:0]              i_size,
    input mem_cfg_pkg::offset_t    i_woffs,
    input mem_cfg_pkg::lane_mask_t i_wmask,
    input logic                    i_ren,
    input logic                    i_rvalid
);

    import mem_cfg_pkg::*;
    import mem_ops_pkg::*;

    int fail_count = 0;  // Failed assertion count

    // Lane k is written when it lies within the store size above the offset
    function automatic lane_mask_t expected_mask(input size_t size, input offset_t offs);
        lane_mask_t mask;
        int         nbytes;
        case (size)
            BYTE:    nbytes = 1;
            HALF:    nbytes = 2;
            WORD:    nbytes = 4;
            default: nbytes = 0;
        endcase
        for (int k = 0; k < LANES; k++) begin
            mask[k] = (int'(offset_t'(k - offs)) < nbytes);  // Distance from offset, mod 4
        end
        return mask;
    endfunction

    a_mask_on: assert property (@(posedge clk) disable iff (i_rst)
        i_wen |-> (i_wmask == expected_mask(size_t'(i_size), i_woffs)))
    else begin
        $error("lane write mask does not match size and offset");
        fail_count++;
    end

    // No lane may be written without a store strobe
    a_mask_off: assert property (@(posedge clk) disable iff (i_rst)
        !i_wen |-> (i_wmask == '0))
    else begin
        $error("lane write enable raised without a store");
        fail_count++;
    end

    a_valid_after_read: assert property (@(posedge clk) disable iff (i_rst)
        i_ren |-> ##2 i_rvalid)
    else begin
        $error("read valid missing two cycles after a read");
        fail_count++;
    end

    a_valid_has_read: assert property (@(posedge clk) disable iff (i_rst)
        i_rvalid |-> $past(i_ren, 2))
    else begin
        $error("read valid without a read two cycles before");
        fail_count++;
    end

endmodule

// Steering mask and read valid seen from the top level
bind data_mem_top data_mem_checker u_checker (
    .clk      (clk),
    .i_rst    (i_rst),
    .i_wen    (i_wen),
    .i_size   (i_size),
    .i_woffs  (i_waddr[1:0]),
    .i_wmask  (u_steer.wmask),
    .i_ren    (i_ren),
    .i_rvalid (o_rvalid)
);

`default_nettype wire

//--- bench/data_mem_tb.sv
// Testbench for the data memory top level
// Stimulus table, shadow byte memory, compare tasks and watchdog
`timescale 1ns/1ps
`default_nettype none

module data_mem_tb;

    import mem_cfg_pkg::*;
    import mem_ops_pkg::*;

    localparam int ADDR_WIDTH = 10;
    localparam int MEM_BYTES  = 2 ** ADDR_WIDTH;
    localparam int OP_WR      = 0;
    localparam int OP_RD      = 1;
    localparam int OP_WRRD    = 2;  // Write and read at one edge

    typedef logic [ADDR_WIDTH-1:0] addr_t;

    logic  clk;
    logic  i_rst;
    addr_t i_waddr;
    addr_t i_raddr;
    word_t i_din;
    logic  [1:0] i_size;
    logic  i_wen;
    logic  i_ren;
    word_t o_dout;
    logic  o_rvalid;

    // Stimulus table columns
    int    step_op   [$];
    addr_t step_addr [$];
    size_t step_size [$];
    word_t step_data [$];
    string step_name [$];

    lane_data_t shadow [MEM_BYTES];  // Expected memory contents
    word_t      exp_q  [$];
    string      name_q [$];

    word_t      hold_exp;   // Word o_dout should hold
    string      hold_name;
    logic [1:0] ren_pipe;   // Read strobes at the last two falling edges
    logic       exp_valid;
    logic       checking;
    int         data_errs;
    int         valid_errs;
    int         other_errs;
    int         assert_errs;

    data_mem_top #(
        .ADDR_WIDTH(ADDR_WIDTH)
    ) uut (
        .clk      (clk),
        .i_rst    (i_rst),
        .i_waddr  (i_waddr),
        .i_raddr  (i_raddr),
        .i_din    (i_din),
        .i_size   (i_size),
        .i_wen    (i_wen),
        .i_ren    (i_ren),
        .o_dout   (o_dout),
        .o_rvalid (o_rvalid)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic int size_bytes(input size_t size);
        case (size)
            BYTE:    return 1;
            HALF:    return 2;
            WORD:    return 4;
            default: return 0;
        endcase
    endfunction

    // Byte j of the store lands at byte address addr + j
    task automatic model_write(input addr_t addr, input size_t size, input word_t data);
        for (int j = 0; j < size_bytes(size); j++) begin
            shadow[addr + addr_t'(j)] = data[8*j +: 8];
        end
    endtask

    function automatic word_t model_read(input addr_t addr);
        word_t w;
        for (int j = 0; j < LANES; j++) begin
            w[8*j +: 8] = shadow[addr + addr_t'(j)];  // Wraps past the last byte
        end
        return w;
    endfunction

    task automatic add_step(input int op, input addr_t addr, input size_t size,
                            input word_t data, input string name);
        step_op.push_back(op);
        step_addr.push_back(addr);
        step_size.push_back(size);
        step_data.push_back(data);
        step_name.push_back(name);
    endtask

    task automatic build_table();
        for (int w = 0; w < 8; w++) begin
            add_step(OP_WR, addr_t'(4*w), WORD, $urandom(), $sformatf("fill_w%0d", w));
        end
        add_step(OP_WR, 10'h3fc, WORD, $urandom(), "fill_last");
        for (int w = 0; w < 8; w++) begin
            add_step(OP_RD, addr_t'(4*w), WORD, '0, $sformatf("rd_w%0d", w));  // Back to back
        end
        add_step(OP_WR, 10'h000, BYTE, 32'h0000_00a5, "wb_off0");
        add_step(OP_RD, 10'h000, WORD, '0, "rd_b_off0");
        add_step(OP_WR, 10'h005, BYTE, 32'hffff_ff3c, "wb_off1");
        add_step(OP_RD, 10'h004, WORD, '0, "rd_b_off1");
        add_step(OP_WR, 10'h00a, BYTE, 32'h0000_0011, "wb_off2");
        add_step(OP_RD, 10'h008, WORD, '0, "rd_b_off2");
        add_step(OP_WR, 10'h00f, BYTE, 32'h0000_00e7, "wb_off3");
        add_step(OP_RD, 10'h00c, WORD, '0, "rd_b_off3");
        add_step(OP_WR, 10'h010, HALF, 32'h0000_beef, "wh_off0");
        add_step(OP_RD, 10'h010, WORD, '0, "rd_h_off0");
        add_step(OP_WR, 10'h015, HALF, 32'h0000_cafe, "wh_off1");
        add_step(OP_RD, 10'h014, WORD, '0, "rd_h_off1");
        add_step(OP_WR, 10'h01a, HALF, 32'h0000_1234, "wh_off2");
        add_step(OP_RD, 10'h018, WORD, '0, "rd_h_off2");
        add_step(OP_WR, 10'h01f, HALF, 32'h0000_5678, "wh_off3");
        add_step(OP_RD, 10'h01d, WORD, '0, "rd_h_off3");  // High byte in next word
        add_step(OP_RD, 10'h001, WORD, '0, "rd_unal_off1");
        add_step(OP_RD, 10'h006, WORD, '0, "rd_unal_off2");
        add_step(OP_RD, 10'h00b, WORD, '0, "rd_unal_off3");
        add_step(OP_RD, 10'h3fe, WORD, '0, "rd_wrap");
        add_step(OP_WRRD, 10'h008, WORD, 32'hdead_beef, "wrrd_old");
        add_step(OP_RD, 10'h008, WORD, '0, "rd_new");
    endtask

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (act !== exp) begin
            data_errs++;
            $display("Error: %s expected %08h actual %08h", name, exp, act);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            valid_errs++;
            $display("Error: %s expected %0b actual %0b", name, exp, act);
        end
    endtask

    task automatic apply_step(input int idx);
        i_wen = 1'b0;
        i_ren = 1'b0;
        if (step_op[idx] != OP_RD) begin
            i_wen   = 1'b1;
            i_waddr = step_addr[idx];
            i_size  = step_size[idx];
            i_din   = step_data[idx];
        end
        if (step_op[idx] != OP_WR) begin
            i_ren   = 1'b1;
            i_raddr = step_addr[idx];
            exp_q.push_back(model_read(step_addr[idx]));  // Old data on a same-edge write
            name_q.push_back(step_name[idx]);
        end
        if (step_op[idx] != OP_RD) begin
            model_write(step_addr[idx], step_size[idx], step_data[idx]);
        end
    endtask

    // Outputs sampled at the falling edge
    always @(negedge clk) begin
        if (checking) begin
            exp_valid = ren_pipe[1];
            check_bit("o_rvalid", exp_valid, o_rvalid);
            if (exp_valid && exp_q.size() == 0) begin
                other_errs++;
                $display("Read result expected but no read was pending");
            end else if (exp_valid) begin
                hold_exp  = exp_q.pop_front();
                hold_name = name_q.pop_front();
            end
            check_word(hold_name, hold_exp, o_dout);
        end
        ren_pipe = {ren_pipe[0], i_ren};
    end

    initial begin
        #1;
        #((step_op.size() + 20) * 20 * 4);
        $display("Timeout: read results did not all arrive");
        $display("STATUS: FAIL");
        $finish;
    end

    initial begin
        void'($urandom(32'h2cc6_a535));
        i_rst      = 1'b1;
        i_waddr    = '0;
        i_raddr    = '0;
        i_din      = '0;
        i_size     = 2'd0;
        i_wen      = 1'b0;
        i_ren      = 1'b0;
        checking   = 1'b0;
        ren_pipe   = '0;
        hold_exp   = '0;  // Zero out of reset
        hold_name  = "after_reset";
        data_errs  = 0;
        valid_errs = 0;
        other_errs = 0;
        build_table();
        repeat (16) @(posedge clk);
        #2;
        i_rst    = 1'b0;
        checking = 1'b1;
        repeat (4) @(posedge clk);  // Outputs stay quiet while idle
        for (int i = 0; i < step_op.size(); i++) begin
            @(posedge clk);
            #2;
            apply_step(i);
        end
        @(posedge clk);
        #2;
        i_wen = 1'b0;
        i_ren = 1'b0;
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        repeat (3) @(posedge clk);
        assert_errs = uut.u_checker.fail_count;
        $display("Errors: data %0d, valid %0d, other %0d, assertion %0d",
                 data_errs, valid_errs, other_errs, assert_errs);
        if (data_errs + valid_errs + other_errs + assert_errs == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- common/mem_cfg_pkg.sv
// Memory geometry constants
// Word, lane data, byte offset and lane mask types
`default_nettype none

package mem_cfg_pkg;

    localparam int LANES  = 4;  // Byte lanes per word
    localparam int BYTE_W = 8;  // Bits per lane

    typedef logic [LANES*BYTE_W-1:0]   word_t;       // Full data word
    typedef logic [BYTE_W-1:0]         lane_data_t;  // One lane byte
    typedef logic [$clog2(LANES)-1:0]  offset_t;     // Byte offset within a word
    typedef logic [LANES-1:0]          lane_mask_t;  // One bit per lane

endpackage

`default_nettype wire

//--- common/mem_lane_if.sv
// Per-lane interface between write steering, bank and read alignment
// Modports steer, bank and align
`timescale 1ns/1ps
`default_nettype none

interface mem_lane_if #(
    parameter int ADDR_WIDTH = 10
);

    import mem_cfg_pkg::*;

    localparam int WA_W = ADDR_WIDTH - 2;  // Word address width

    logic            wen;    // Lane write enable
    logic [WA_W-1:0] waddr;  // Lane word address, write side
    lane_data_t      wdata;
    logic            ren;
    logic [WA_W-1:0] raddr;  // Lane word address, read side
    lane_data_t      rdata;  // Registered bank output

    modport steer (
        output wen, waddr, wdata, ren, raddr
    );

    modport bank (
        input  wen, waddr, wdata, ren, raddr,
        output rdata
    );

    modport align (
        input rdata
    );

endinterface

`default_nettype wire

//--- common/mem_ops_pkg.sv
// Access size encoding
// Lane write-mask lookup from size and byte offset
`default_nettype none

package mem_ops_pkg;

    import mem_cfg_pkg::*;

    typedef enum logic [1:0] {
        NONE = 2'd0,
        BYTE = 2'd1,
        HALF = 2'd2,
        WORD = 2'd3
    } size_t;

    // Consecutive lanes from offs upward, wrapping lane 3 to lane 0
    function automatic lane_mask_t lane_mask_of(input size_t size, input offset_t offs);
        lane_mask_t               base;
        logic [2*LANES-1:0]       rot;
        case (size)
            BYTE:    base = lane_mask_t'(4'b0001);
            HALF:    base = lane_mask_t'(4'b0011);
            WORD:    base = '1;
            default: base = '0;
        endcase
        rot = {base, base} << offs;  // Upper half holds the rotated mask
        return rot[2*LANES-1 -: LANES];
    endfunction

endpackage

`default_nettype wire

//--- data_mem/mem_bank.sv
// One byte-wide synchronous RAM bank
// Write on wen, registered read on ren
`timescale 1ns/1ps
`default_nettype none

module mem_bank #(
    parameter int ADDR_WIDTH = 10
) (
    input  logic     clk,
    input  logic     i_rst,
    mem_lane_if.bank lane
);

    import mem_cfg_pkg::*;

    localparam int WA_W  = ADDR_WIDTH - 2;
    localparam int DEPTH = 2 ** WA_W;  // Words per bank

    lane_data_t ram [DEPTH];

    always_ff @(posedge clk) begin
        if (lane.wen) begin
            ram[lane.waddr] <= lane.wdata;
        end
    end

    // Same-edge write is not seen, old byte comes out
    always_ff @(posedge clk) begin
        if (i_rst) begin
            lane.rdata <= '0;
        end else if (lane.ren) begin
            lane.rdata <= ram[lane.raddr];
        end
    end

endmodule

`default_nettype wire

//--- data_mem/mem_read_align.sv
// Read alignment
// Offset delay stage and registered lane rotation into the read word
`timescale 1ns/1ps
`default_nettype none

module mem_read_align (
    input  logic                   clk,
    input  logic                   i_rst,
    input  logic                   i_ren,
    input  mem_cfg_pkg::offset_t   i_roffs,
    mem_lane_if.align              lanes [mem_cfg_pkg::LANES],
    output mem_cfg_pkg::word_t     o_dout,
    output logic                   o_rvalid
);

    import mem_cfg_pkg::*;

    logic       ren_d;   // Lines up with bank rdata
    offset_t    offs_d;
    lane_data_t lane_byte [LANES];
    word_t      rot;     // Bytes back in address order

    // Stage 1 matches the bank read register
    always_ff @(posedge clk) begin
        if (i_rst) begin
            ren_d  <= 1'b0;
            offs_d <= '0;
        end else begin
            ren_d  <= i_ren;
            offs_d <= i_roffs;
        end
    end

    for (genvar k = 0; k < LANES; k++) begin : g_lane
        assign lane_byte[k] = lanes[k].rdata;
    end

    for (genvar j = 0; j < LANES; j++) begin : g_byte
        offset_t sel;

        assign sel = offset_t'(j) + offs_d;  // Wraps past lane 3
        assign rot[BYTE_W*j +: BYTE_W] = lane_byte[sel];
    end

    // Stage 2 output word holds between reads
    always_ff @(posedge clk) begin
        if (i_rst) begin
            o_dout   <= '0;
            o_rvalid <= 1'b0;
        end else begin
            o_rvalid <= ren_d;
            if (ren_d) begin
                o_dout <= rot;
            end
        end
    end

endmodule

`default_nettype wire

//--- data_mem/mem_write_steer.sv
// Write steering for the four byte banks
// Lane write mask, per-lane word addresses and rotated store data
`timescale 1ns/1ps
`default_nettype none

module mem_write_steer #(
    parameter int ADDR_WIDTH = 10
) (
    input  logic [ADDR_WIDTH-1:0] i_waddr,
    input  logic [ADDR_WIDTH-1:0] i_raddr,
    input  mem_cfg_pkg::word_t    i_din,
    input  mem_ops_pkg::size_t    i_size,
    input  logic                  i_wen,
    input  logic                  i_ren,
    mem_lane_if.steer             lanes [mem_cfg_pkg::LANES]
);

    import mem_cfg_pkg::*;
    import mem_ops_pkg::*;

    localparam int WA_W = ADDR_WIDTH - 2;

    typedef logic [WA_W-1:0] waddr_t;

    waddr_t     wbase;  // Word address of the first byte
    waddr_t     rbase;
    offset_t    woffs;
    offset_t    roffs;
    lane_mask_t wmask;

    assign wbase = i_waddr[ADDR_WIDTH-1:2];
    assign rbase = i_raddr[ADDR_WIDTH-1:2];
    assign woffs = i_waddr[1:0];
    assign roffs = i_raddr[1:0];

    // Only the lanes touched by the store
    assign wmask = i_wen ? lane_mask_of(i_size, woffs) : '0;

    for (genvar k = 0; k < LANES; k++) begin : g_lane
        localparam offset_t LANE = offset_t'(k);

        offset_t src;  // Store byte that lands on this lane

        // 2-bit subtract wraps the lane index
        assign src = LANE - woffs;

        assign lanes[k].wen   = wmask[k];
        assign lanes[k].wdata = i_din[BYTE_W*src +: BYTE_W];

        // Lanes below the offset belong to the next word
        assign lanes[k].waddr = wbase + WA_W'(LANE < woffs);
        assign lanes[k].raddr = rbase + WA_W'(LANE < roffs);

        assign lanes[k].ren = i_ren;  // Every lane reads on a read strobe
    end

endmodule

`default_nettype wire

//--- flist.f
common/mem_cfg_pkg.sv
common/mem_ops_pkg.sv
common/mem_lane_if.sv
data_mem/mem_write_steer.sv
data_mem/mem_bank.sv
data_mem/mem_read_align.sv
verilog/data_mem_top.sv
bench/data_mem_checker.sv
bench/data_mem_tb.sv

//--- verilog/data_mem_top.sv
// Data memory top level
// Write steering, four byte banks and read alignment over lane interfaces
`timescale 1ns/1ps
`default_nettype none

module data_mem_top #(
    parameter int ADDR_WIDTH = 10
) (
    input  logic                  clk,
    input  logic                  i_rst,
    input  logic [ADDR_WIDTH-1:0] i_waddr,
    input  logic [ADDR_WIDTH-1:0] i_raddr,
    input  logic [31:0]           i_din,
    input  logic [1:0]            i_size,
    input  logic                  i_wen,
    input  logic                  i_ren,
    output logic [31:0]           o_dout,
    output logic                  o_rvalid
);

    import mem_cfg_pkg::*;
    import mem_ops_pkg::*;

    mem_lane_if #(.ADDR_WIDTH(ADDR_WIDTH)) lanes [LANES] ();

    mem_write_steer #(
        .ADDR_WIDTH(ADDR_WIDTH)
    ) u_steer (
        .i_waddr (i_waddr),
        .i_raddr (i_raddr),
        .i_din   (i_din),
        .i_size  (size_t'(i_size)),
        .i_wen   (i_wen),
        .i_ren   (i_ren),
        .lanes   (lanes)
    );

    // One bank per byte lane
    for (genvar k = 0; k < LANES; k++) begin : g_lane
        mem_bank #(
            .ADDR_WIDTH(ADDR_WIDTH)
        ) u_bank (
            .clk   (clk),
            .i_rst (i_rst),
            .lane  (lanes[k])
        );
    end

    mem_read_align u_align (
        .clk      (clk),
        .i_rst    (i_rst),
        .i_ren    (i_ren),
        .i_roffs  (i_raddr[1:0]),  // Byte offset of the read
        .lanes    (lanes),
        .o_dout   (o_dout),
        .o_rvalid (o_rvalid)
    );

endmodule

`default_nettype wire
